/* src/vdp_mode_pkg.sv */
// Screen mode definitions for the VDP command engine
// Mode encoding, coordinate and address types, X limits
`default_nettype none

package vdp_mode_pkg;

  // Bitmap modes the command engine can draw into
  typedef enum logic [1:0] {
    MODE_G4 = 2'd0,
    MODE_G5 = 2'd1,
    MODE_G6 = 2'd2,
    MODE_G7 = 2'd3
  } screen_mode_t;

  // 128 KiB VRAM byte address
  typedef logic [16:0] vram_addr_t;

  // Dot coordinates and counts
  typedef logic [8:0] coord_x_t;
  typedef logic [9:0] coord_y_t;
  typedef logic [9:0] count_t;

  // Colour code or raw VRAM byte
  typedef logic [7:0] colour_t;

  // Row widths in dots, GRAPHIC 5 and 6 use the wide one
  localparam int X_LIMIT_NARROW = 256;
  localparam int X_LIMIT_WIDE   = 512;

endpackage

`default_nettype wire

/* src/vdp_cmd_pkg.sv */
// Command definitions for the VDP command engine
// Opcodes, logical operations, sequencer states and register offsets
`default_nettype none

package vdp_cmd_pkg;

  // CMR bits 7..4, anything else decodes as STOP
  typedef enum logic [3:0] {
    OP_STOP  = 4'b0000,
    OP_POINT = 4'b0100,
    OP_PSET  = 4'b0101,
    OP_LMMV  = 4'b1000,
    OP_HMMV  = 4'b1100
  } cmd_op_t;

  // CMR bits 2..0
  typedef enum logic [2:0] {
    LOG_IMP = 3'b000,
    LOG_AND = 3'b001,
    LOG_OR  = 3'b010,
    LOG_XOR = 3'b011,
    LOG_NOT = 3'b100
  } log_op_t;

  typedef enum logic [3:0] {
    ST_IDLE    = 4'd0,
    ST_ISSUE   = 4'd1,
    ST_RD_WAIT = 4'd2,
    ST_WR_WAIT = 4'd3,
    ST_STEP    = 4'd4
  } seq_state_t;

  // Register offsets, R32 onward
  localparam logic [3:0] REG_SX_LO = 4'd0;
  localparam logic [3:0] REG_SX_HI = 4'd1;
  localparam logic [3:0] REG_SY_LO = 4'd2;
  localparam logic [3:0] REG_SY_HI = 4'd3;
  localparam logic [3:0] REG_DX_LO = 4'd4;
  localparam logic [3:0] REG_DX_HI = 4'd5;
  localparam logic [3:0] REG_DY_LO = 4'd6;
  localparam logic [3:0] REG_DY_HI = 4'd7;
  localparam logic [3:0] REG_NX_LO = 4'd8;
  localparam logic [3:0] REG_NX_HI = 4'd9;
  localparam logic [3:0] REG_NY_LO = 4'd10;
  localparam logic [3:0] REG_NY_HI = 4'd11;
  localparam logic [3:0] REG_CLR   = 4'd12;
  localparam logic [3:0] REG_ARG   = 4'd13;
  localparam logic [3:0] REG_CMR   = 4'd14;

endpackage

`default_nettype wire

/* src/vdp_cmd_regs_if.sv */
// Command register bundle between register file and sequencer
// Carries the POINT result back into the colour register
`timescale 1ns/1ns
`default_nettype none

interface cmd_regs_if;
  import vdp_mode_pkg::*;
  import vdp_cmd_pkg::*;

  coord_x_t sx;
  coord_y_t sy;
  coord_x_t dx;
  coord_y_t dy;
  count_t   nx;
  count_t   ny;
  colour_t  clr;
  logic     dix;
  logic     diy;
  cmd_op_t  op;
  log_op_t  log_op;
  logic     transparent;
  // One cycle per CMR write
  logic     start;
  // POINT readback
  logic     point_load;
  colour_t  point_data;

  modport regs_mp (
    output sx, sy, dx, dy, nx, ny, clr, dix, diy, op, log_op, transparent, start,
    input  point_load, point_data
  );

  modport seq_mp (
    input  dx, dy, nx, ny, clr, dix, diy, op, start,
    output point_load, point_data
  );

endinterface

`default_nettype wire

/* src/vdp_cmd_regs.sv */
// VDP command register file
// Takes CPU register writes over a toggle handshake, pulses start on CMR
`timescale 1ns/1ns
`default_nettype none

module vdp_cmd_regs (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  reg_wr_req,
  input  logic [3:0]            reg_num,
  input  vdp_mode_pkg::colour_t reg_data,
  output logic                  reg_wr_ack,
  input  vdp_mode_pkg::colour_t colour_mask,
  cmd_regs_if.regs_mp           regs
);
  import vdp_cmd_pkg::*;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_wr_ack       <= 1'b0;
      regs.sx          <= '0;
      regs.sy          <= '0;
      regs.dx          <= '0;
      regs.dy          <= '0;
      regs.nx          <= '0;
      regs.ny          <= '0;
      regs.clr         <= '0;
      regs.dix         <= 1'b0;
      regs.diy         <= 1'b0;
      regs.op          <= OP_STOP;
      regs.log_op      <= LOG_IMP;
      regs.transparent <= 1'b0;
      regs.start       <= 1'b0;
    end else begin
      regs.start <= 1'b0;
      // Pending write while req and ack differ
      if (reg_wr_req != reg_wr_ack) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          REG_SX_LO: regs.sx[7:0] <= reg_data;
          REG_SX_HI: regs.sx[8]   <= reg_data[0];
          REG_SY_LO: regs.sy[7:0] <= reg_data;
          REG_SY_HI: regs.sy[9:8] <= reg_data[1:0];
          REG_DX_LO: regs.dx[7:0] <= reg_data;
          REG_DX_HI: regs.dx[8]   <= reg_data[0];
          REG_DY_LO: regs.dy[7:0] <= reg_data;
          REG_DY_HI: regs.dy[9:8] <= reg_data[1:0];
          REG_NX_LO: regs.nx[7:0] <= reg_data;
          REG_NX_HI: regs.nx[9:8] <= reg_data[1:0];
          REG_NY_LO: regs.ny[7:0] <= reg_data;
          REG_NY_HI: regs.ny[9:8] <= reg_data[1:0];
          // Colour trimmed to the pixel width of the current mode
          REG_CLR: regs.clr <= reg_data & colour_mask;
          REG_ARG: begin
            regs.dix <= reg_data[2];
            regs.diy <= reg_data[3];
          end
          REG_CMR: begin
            // Unsupported opcodes behave as STOP
            case (reg_data[7:4])
              OP_HMMV, OP_LMMV, OP_PSET, OP_POINT: regs.op <= cmd_op_t'(reg_data[7:4]);
              default: regs.op <= OP_STOP;
            endcase
            regs.transparent <= reg_data[3];
            regs.log_op      <= log_op_t'(reg_data[2:0]);
            // Aborts and restarts the sequencer
            regs.start       <= 1'b1;
          end
          default: ;
        endcase
      end
      // POINT result lands in CLR
      if (regs.point_load) begin
        regs.clr <= regs.point_data;
      end
    end
  end

endmodule

`default_nettype wire

/* src/vdp_pixel_unit.sv */
// Pixel datapath for the command engine
// Address mapping, pixel extract, logical operation and byte merge per mode
`timescale 1ns/1ns
`default_nettype none

module vdp_pixel_unit (
  input  vdp_mode_pkg::screen_mode_t screen_mode,
  input  vdp_mode_pkg::coord_x_t     x,
  input  vdp_mode_pkg::coord_y_t     y,
  input  vdp_cmd_pkg::cmd_op_t       op,
  input  vdp_cmd_pkg::log_op_t       log_op,
  input  logic                       transparent,
  input  vdp_mode_pkg::colour_t      src_colour,
  input  vdp_mode_pkg::colour_t      rd_byte,
  output vdp_mode_pkg::vram_addr_t   addr,
  output vdp_mode_pkg::colour_t      colour_mask,
  output logic [2:0]                 x_step,
  output vdp_mode_pkg::colour_t      point,
  output vdp_mode_pkg::colour_t      merged_byte
);
  import vdp_mode_pkg::*;
  import vdp_cmd_pkg::*;

  // Right-aligned mask of one pixel
  colour_t    pix_mask;
  // Bit position of x's pixel inside the byte
  logic [2:0] shift;
  logic [2:0] pix_per_byte;
  colour_t    src_masked;
  colour_t    result;

  // Mode geometry, leftmost pixel in the high bits
  always_comb begin
    addr         = '0;
    pix_mask     = 8'hff;
    shift        = 3'd0;
    pix_per_byte = 3'd1;
    case (screen_mode)
      MODE_G4: begin
        addr         = {y[9:0], x[7:1]};
        pix_mask     = 8'h0f;
        shift        = {~x[0], 2'b00};
        pix_per_byte = 3'd2;
      end
      MODE_G5: begin
        addr         = {y[9:0], x[8:2]};
        pix_mask     = 8'h03;
        shift        = {~x[1:0], 1'b0};
        pix_per_byte = 3'd4;
      end
      MODE_G6: begin
        addr         = {y[8:0], x[8:1]};
        pix_mask     = 8'h0f;
        shift        = {~x[0], 2'b00};
        pix_per_byte = 3'd2;
      end
      MODE_G7: begin
        // One pixel per byte
        addr         = {y[8:0], x[7:0]};
        pix_mask     = 8'hff;
        shift        = 3'd0;
        pix_per_byte = 3'd1;
      end
      default: ;
    endcase
  end

  // Byte commands work on whole bytes
  assign colour_mask = (op == OP_HMMV) ? 8'hff : pix_mask;
  assign x_step      = (op == OP_HMMV) ? pix_per_byte : 3'd1;

  assign point      = (rd_byte >> shift) & pix_mask;
  assign src_masked = src_colour & colour_mask;

  // Logical operation, destination kept on transparent zero
  always_comb begin
    if (transparent && (src_masked == '0)) begin
      result = point;
    end else begin
      case (log_op)
        LOG_IMP: result = src_masked;
        LOG_AND: result = src_masked & point;
        LOG_OR:  result = src_masked | point;
        LOG_XOR: result = src_masked ^ point;
        LOG_NOT: result = ~src_masked;
        default: result = point;
      endcase
    end
  end

  // Other pixels of the byte pass through
  assign merged_byte = (rd_byte & ~(pix_mask << shift)) | ((result & pix_mask) << shift);

endmodule

`default_nettype wire

/* src/vdp_cmd_seq.sv */
// Command sequencer FSM
// Walks the rectangle and drives the VRAM read and write toggle channels
`timescale 1ns/1ns
`default_nettype none

module vdp_cmd_seq (
  input  logic                   clk,
  input  logic                   reset,
  cmd_regs_if.seq_mp             regs,
  output vdp_mode_pkg::coord_x_t cur_x,
  output vdp_mode_pkg::coord_y_t cur_y,
  input  logic [2:0]             x_step,
  input  logic                   x_limit_wide,
  input  vdp_mode_pkg::colour_t  point,
  input  vdp_mode_pkg::colour_t  merged_byte,
  output logic                   vram_rd_req,
  input  logic                   vram_rd_ack,
  output logic                   vram_wr_req,
  input  logic                   vram_wr_ack,
  output vdp_mode_pkg::colour_t  vram_wr_data,
  output logic                   ce
);
  import vdp_mode_pkg::*;
  import vdp_cmd_pkg::*;

  seq_state_t state;

  // Working copies, one extra X bit catches the row limit and wrap
  logic [9:0] x_work;
  coord_y_t   y_work;
  count_t     nx_cnt;
  count_t     ny_cnt;

  count_t     nx_start;
  logic [9:0] x_next;
  count_t     nx_next;
  coord_y_t   y_next;
  logic       past_limit;
  logic       row_end;
  logic       rd_busy;
  logic       wr_busy;

  assign cur_x = x_work[8:0];
  assign cur_y = y_work;

  assign rd_busy = (vram_rd_req != vram_rd_ack);
  assign wr_busy = (vram_wr_req != vram_wr_ack);

  // HMMV counts bytes instead of dots
  always_comb begin
    case (x_step)
      3'd4:    nx_start = {2'b00, regs.nx[9:2]};
      3'd2:    nx_start = {1'b0, regs.nx[9:1]};
      default: nx_start = regs.nx;
    endcase
  end

  assign x_next  = regs.dix ? (x_work - {7'd0, x_step}) : (x_work + {7'd0, x_step});
  assign nx_next = nx_cnt - 10'd1;
  assign y_next  = regs.diy ? (y_work - 10'd1) : (y_work + 10'd1);

  // Left steps below 0 wrap high and also count as past the limit
  assign past_limit = x_limit_wide ? (x_next >= 10'(X_LIMIT_WIDE))
                                   : (x_next >= 10'(X_LIMIT_NARROW));
  assign row_end    = (nx_next == '0) || past_limit;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state           <= ST_IDLE;
      ce              <= 1'b0;
      x_work          <= '0;
      y_work          <= '0;
      nx_cnt          <= '0;
      ny_cnt          <= '0;
      vram_rd_req     <= 1'b0;
      vram_wr_req     <= 1'b0;
      vram_wr_data    <= '0;
      regs.point_load <= 1'b0;
      regs.point_data <= '0;
    end else begin
      regs.point_load <= 1'b0;
      if (regs.start) begin
        // New command, any running one is dropped
        x_work <= {1'b0, regs.dx};
        y_work <= regs.dy;
        nx_cnt <= nx_start;
        ny_cnt <= (regs.ny == '0) ? 10'd1 : regs.ny;
        if (regs.op == OP_STOP) begin
          ce    <= 1'b0;
          state <= ST_IDLE;
        end else begin
          ce    <= 1'b1;
          state <= ST_ISSUE;
        end
      end else begin
        case (state)
          ST_IDLE: begin
            ce <= 1'b0;
          end
          ST_ISSUE: begin
            // Let an aborted transfer finish before toggling again
            if (!rd_busy && !wr_busy) begin
              case (regs.op)
                OP_HMMV: begin
                  vram_wr_data <= regs.clr;
                  vram_wr_req  <= ~vram_wr_ack;
                  state        <= ST_WR_WAIT;
                end
                OP_LMMV, OP_PSET, OP_POINT: begin
                  vram_rd_req <= ~vram_rd_ack;
                  state       <= ST_RD_WAIT;
                end
                default: begin
                  ce    <= 1'b0;
                  state <= ST_IDLE;
                end
              endcase
            end
          end
          ST_RD_WAIT: begin
            if (!rd_busy) begin
              if (regs.op == OP_POINT) begin
                regs.point_load <= 1'b1;
                regs.point_data <= point;
                ce              <= 1'b0;
                state           <= ST_IDLE;
              end else begin
                // Read-modify-write of the destination byte
                vram_wr_data <= merged_byte;
                vram_wr_req  <= ~vram_wr_ack;
                state        <= ST_WR_WAIT;
              end
            end
          end
          ST_WR_WAIT: begin
            if (!wr_busy) begin
              if (regs.op == OP_PSET) begin
                ce    <= 1'b0;
                state <= ST_IDLE;
              end else begin
                state <= ST_STEP;
              end
            end
          end
          ST_STEP: begin
            if (!row_end) begin
              x_work <= x_next;
              nx_cnt <= nx_next;
              state  <= ST_ISSUE;
            end else if (ny_cnt == 10'd1) begin
              // Last row done
              ce    <= 1'b0;
              state <= ST_IDLE;
            end else begin
              // Next row from DX again
              x_work <= {1'b0, regs.dx};
              y_work <= y_next;
              nx_cnt <= nx_start;
              ny_cnt <= ny_cnt - 10'd1;
              state  <= ST_ISSUE;
            end
          end
          default: begin
            ce    <= 1'b0;
            state <= ST_IDLE;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* src/vdp_command.sv */
// VDP drawing command engine top level
// Register file, sequencer and pixel datapath behind plain ports
`timescale 1ns/1ns
`default_nettype none

module vdp_command (
  input  logic                       clk,
  input  logic                       reset,
  input  vdp_mode_pkg::screen_mode_t screen_mode,
  input  logic                       reg_wr_req,
  input  logic [3:0]                 reg_num,
  input  vdp_mode_pkg::colour_t      reg_data,
  output logic                       reg_wr_ack,
  output logic                       vram_rd_req,
  input  logic                       vram_rd_ack,
  input  vdp_mode_pkg::colour_t      vram_rd_data,
  output logic                       vram_wr_req,
  input  logic                       vram_wr_ack,
  output vdp_mode_pkg::colour_t      vram_wr_data,
  output vdp_mode_pkg::vram_addr_t   vram_addr,
  output vdp_mode_pkg::colour_t      clr,
  output logic                       ce
);
  import vdp_mode_pkg::*;
  import vdp_cmd_pkg::*;

  coord_x_t   cur_x;
  coord_y_t   cur_y;
  coord_x_t   px_x;
  coord_y_t   px_y;
  logic [2:0] x_step;
  logic       x_limit_wide;
  logic       point_active;
  colour_t    colour_mask;
  colour_t    point;
  colour_t    merged_byte;

  cmd_regs_if regs_if ();

  // GRAPHIC 5 and 6 are 512 dots wide
  assign x_limit_wide = (screen_mode == MODE_G5) || (screen_mode == MODE_G6);

  // POINT reads from the source coordinates
  assign point_active = ce && (regs_if.op == OP_POINT);
  assign px_x         = point_active ? regs_if.sx : cur_x;
  assign px_y         = point_active ? regs_if.sy : cur_y;

  assign clr = regs_if.clr;

  vdp_cmd_regs regs_i (
    .clk         (clk),
    .reset       (reset),
    .reg_wr_req  (reg_wr_req),
    .reg_num     (reg_num),
    .reg_data    (reg_data),
    .reg_wr_ack  (reg_wr_ack),
    .colour_mask (colour_mask),
    .regs        (regs_if.regs_mp)
  );

  vdp_cmd_seq seq_i (
    .clk          (clk),
    .reset        (reset),
    .regs         (regs_if.seq_mp),
    .cur_x        (cur_x),
    .cur_y        (cur_y),
    .x_step       (x_step),
    .x_limit_wide (x_limit_wide),
    .point        (point),
    .merged_byte  (merged_byte),
    .vram_rd_req  (vram_rd_req),
    .vram_rd_ack  (vram_rd_ack),
    .vram_wr_req  (vram_wr_req),
    .vram_wr_ack  (vram_wr_ack),
    .vram_wr_data (vram_wr_data),
    .ce           (ce)
  );

  vdp_pixel_unit pixel_i (
    .screen_mode (screen_mode),
    .x           (px_x),
    .y           (px_y),
    .op          (regs_if.op),
    .log_op      (regs_if.log_op),
    .transparent (regs_if.transparent),
    .src_colour  (regs_if.clr),
    .rd_byte     (vram_rd_data),
    .addr        (vram_addr),
    .colour_mask (colour_mask),
    .x_step      (x_step),
    .point       (point),
    .merged_byte (merged_byte)
  );

endmodule

`default_nettype wire

/* dv/vram_model.sv */
// Behavioral VRAM for the command engine testbench
// 128 KiB, toggle read and write channels with a random response delay
`timescale 1ns/1ns
`default_nettype none

module vram_model #(
  parameter int MAX_DELAY = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     rd_req,
  output logic                     rd_ack,
  output vdp_mode_pkg::colour_t    rd_data,
  input  logic                     wr_req,
  output logic                     wr_ack,
  input  vdp_mode_pkg::colour_t    wr_data,
  input  vdp_mode_pkg::vram_addr_t addr
);
  import vdp_mode_pkg::*;

  colour_t     mem [0:131071];
  logic [31:0] lcg_state;
  int          wait_cnt;
  logic        busy;

  // 32-bit LCG step
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Fill pattern mixes every address bit
  initial begin
    for (int a = 0; a < 131072; a++) begin
      mem[a] = 8'(a * 7) ^ 8'(a >> 8) ^ 8'(a >> 16);
    end
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_ack    <= 1'b0;
      wr_ack    <= 1'b0;
      rd_data   <= '0;
      lcg_state <= 32'd97;
      wait_cnt  <= 0;
      busy      <= 1'b0;
    end else if ((rd_req != rd_ack) || (wr_req != wr_ack)) begin
      if (!busy) begin
        // New request, draw its delay
        busy      <= 1'b1;
        wait_cnt  <= int'(lcg_state[18:16]) % MAX_DELAY;
        lcg_state <= lcg_next(lcg_state);
      end else if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;
      end else begin
        busy <= 1'b0;
        if (rd_req != rd_ack) begin
          rd_data <= mem[addr];
          rd_ack  <= ~rd_ack;
        end else begin
          mem[addr] <= wr_data;
          wr_ack    <= ~wr_ack;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_vdp_command.sv */
// Testbench for the VDP command engine
// Drives register writes, mirrors VRAM in a shadow copy and checks results
`timescale 1ns/1ns
`default_nettype none

module tb_vdp_command;
  import vdp_mode_pkg::*;
  import vdp_cmd_pkg::*;

  localparam int VRAM_BYTES = 131072;
  localparam int MAX_DELAY = 4;
  localparam int CMD_TIMEOUT = 2000;
  // Access budget: PSETs, two HMMV and two LMMV fills, POINT, abort
  localparam int VRAM_ACCESSES = 5 * 2 + 2 * 12 + 2 * 2 * 24 + 1 + 16;
  localparam int REG_WRITES = 100;
  localparam int WATCHDOG_CYCLES = 3 * (VRAM_ACCESSES * (MAX_DELAY + 6) + REG_WRITES * 3 + 16);

  logic         clk = 1'b0;
  logic         reset;
  screen_mode_t screen_mode;
  logic         reg_wr_req;
  logic [3:0]   reg_num;
  colour_t      reg_data;
  logic         reg_wr_ack;
  logic         vram_rd_req;
  logic         vram_rd_ack;
  colour_t      vram_rd_data;
  logic         vram_wr_req;
  logic         vram_wr_ack;
  colour_t      vram_wr_data;
  vram_addr_t   vram_addr;
  colour_t      clr;
  logic         ce;

  // Reference state
  colour_t      shadow [0:VRAM_BYTES-1];
  screen_mode_t mode_now;
  logic [3:0]   last_op;
  logic [2:0]   lop_now;
  logic         transp_now;
  colour_t      clr_now;
  int           errors = 0;
  int           errors_before = 0;
  int           passes = 0;
  int           fails = 0;

  always #10 clk = ~clk;

  vdp_command dut_i (
    .clk          (clk),
    .reset        (reset),
    .screen_mode  (screen_mode),
    .reg_wr_req   (reg_wr_req),
    .reg_num      (reg_num),
    .reg_data     (reg_data),
    .reg_wr_ack   (reg_wr_ack),
    .vram_rd_req  (vram_rd_req),
    .vram_rd_ack  (vram_rd_ack),
    .vram_rd_data (vram_rd_data),
    .vram_wr_req  (vram_wr_req),
    .vram_wr_ack  (vram_wr_ack),
    .vram_wr_data (vram_wr_data),
    .vram_addr    (vram_addr),
    .clr          (clr),
    .ce           (ce)
  );

  vram_model #(.MAX_DELAY(MAX_DELAY)) vram_i (
    .clk     (clk),
    .reset   (reset),
    .rd_req  (vram_rd_req),
    .rd_ack  (vram_rd_ack),
    .rd_data (vram_rd_data),
    .wr_req  (vram_wr_req),
    .wr_ack  (vram_wr_ack),
    .wr_data (vram_wr_data),
    .addr    (vram_addr)
  );

  // Read and write channels are never busy together
  no_overlap: assert property (@(posedge clk) disable iff (reset)
    !((vram_rd_req != vram_rd_ack) && (vram_wr_req != vram_wr_ack)))
  else begin
    $display("VRAM read and write requests were pending at the same time");
    errors++;
  end

  function automatic int bits_per_pixel(input screen_mode_t m);
    case (m)
      MODE_G5: return 2;
      MODE_G7: return 8;
      default: return 4;
    endcase
  endfunction

  function automatic int byte_addr(input screen_mode_t m, input int x, input int y);
    case (m)
      MODE_G4: return (y % 1024) * 128 + (x % 256) / 2;
      MODE_G5: return (y % 1024) * 128 + (x % 512) / 4;
      MODE_G6: return (y % 512) * 256 + (x % 512) / 2;
      default: return (y % 512) * 256 + (x % 256);
    endcase
  endfunction

  // Leftmost pixel sits in the high bits
  function automatic int pixel_shift(input screen_mode_t m, input int x);
    int bpp;
    int ppb;
    bpp = bits_per_pixel(m);
    ppb = 8 / bpp;
    return (ppb - 1 - (x % ppb)) * bpp;
  endfunction

  function automatic colour_t colour_mask_for(input screen_mode_t m, input logic [3:0] op);
    if (op == OP_HMMV) return 8'hff;
    return 8'((1 << bits_per_pixel(m)) - 1);
  endfunction

  function automatic colour_t logic_pixel(input logic [2:0] lop, input logic transp,
                                          input colour_t src, input colour_t dst);
    if (transp && (src == 8'h00)) return dst;
    case (lop)
      LOG_IMP: return src;
      LOG_AND: return src & dst;
      LOG_OR:  return src | dst;
      LOG_XOR: return src ^ dst;
      LOG_NOT: return ~src;
      default: return dst;
    endcase
  endfunction

  task automatic expect_value(input string name, input colour_t got, input colour_t exp);
    assert (got == exp) else begin
      $display("ERR %s expected %02h got %02h", name, exp, got);
      errors++;
    end
  endtask

  // One toggle write, acknowledge exactly one cycle later
  task automatic write_reg(input logic [3:0] idx, input colour_t data);
    logic want;
    @(posedge clk);
    reg_num    <= idx;
    reg_data   <= data;
    reg_wr_req <= ~reg_wr_req;
    @(negedge clk);
    want = ~reg_wr_req;
    expect_value("reg_wr_ack", 8'(reg_wr_ack), 8'(want));
    @(negedge clk);
    want = reg_wr_req;
    expect_value("reg_wr_ack", 8'(reg_wr_ack), 8'(want));
  endtask

  task automatic write_word(input logic [3:0] lo_idx, input int value);
    write_reg(lo_idx, value[7:0]);
    write_reg(lo_idx + 4'd1, value[15:8]);
  endtask

  task automatic set_mode(input screen_mode_t m);
    @(posedge clk);
    screen_mode <= m;
    mode_now = m;
  endtask

  // CLR is trimmed by the mask of the mode and the last command
  task automatic set_colour(input colour_t value);
    clr_now = value & colour_mask_for(mode_now, last_op);
    write_reg(REG_CLR, value);
    expect_value("clr", clr, clr_now);
  endtask

  task automatic set_rect(input int dx, input int dy, input int nx, input int ny,
                          input colour_t arg);
    write_word(REG_DX_LO, dx);
    write_word(REG_DY_LO, dy);
    write_word(REG_NX_LO, nx);
    write_word(REG_NY_LO, ny);
    write_reg(REG_ARG, arg);
  endtask

  // Start a command and wait for ce to drop
  task automatic run_command(input colour_t cmr);
    int cycles;
    write_reg(REG_CMR, cmr);
    last_op    = cmr[7:4];
    lop_now    = cmr[2:0];
    transp_now = cmr[3];
    cycles     = 0;
    @(negedge clk);
    expect_value("ce", 8'(ce), (cmr[7:4] == OP_STOP) ? 8'h00 : 8'h01);
    while (ce && (cycles < CMD_TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    if (ce) begin
      $display("Command %02h still running after %0d cycles", cmr, CMD_TIMEOUT);
      errors++;
    end
  endtask

  task automatic model_pixel(input int x, input int y);
    int      a;
    int      sh;
    colour_t pm;
    colour_t dst;
    colour_t res;
    a   = byte_addr(mode_now, x, y);
    sh  = pixel_shift(mode_now, x);
    pm  = colour_mask_for(mode_now, OP_LMMV);
    dst = (shadow[a] >> sh) & pm;
    res = logic_pixel(lop_now, transp_now, clr_now & pm, dst) & pm;
    shadow[a] = (shadow[a] & ~(pm << sh)) | (res << sh);
  endtask

  // Rectangle walk, byte steps for HMMV and dot steps otherwise
  task automatic model_rect(input logic byte_mode, input int dx, input int dy, input int nx,
                            input int ny, input logic dix, input logic diy);
    int step;
    int limit;
    int x;
    int y;
    int cnt;
    step  = byte_mode ? 8 / bits_per_pixel(mode_now) : 1;
    limit = ((mode_now == MODE_G5) || (mode_now == MODE_G6)) ? 512 : 256;
    y     = dy;
    for (int r = 0; r < ((ny == 0) ? 1 : ny); r++) begin
      x   = dx;
      cnt = nx / step;
      do begin
        if (byte_mode) shadow[byte_addr(mode_now, x, y)] = clr_now;
        else model_pixel(x, y);
        x   = dix ? x - step : x + step;
        cnt = cnt - 1;
      end while ((cnt > 0) && (x >= 0) && (x < limit));
      y = diy ? y - 1 : y + 1;
    end
  endtask

  task automatic check_memory(input string what);
    int bad;
    bad = 0;
    for (int a = 0; a < VRAM_BYTES; a++) begin
      assert (vram_i.mem[a] == shadow[a]) else begin
        if (bad < 4) $display("ERR vram[%05h] expected %02h got %02h after %s",
                              a, shadow[a], vram_i.mem[a], what);
        bad++;
      end
    end
    errors += bad;
  endtask

  task automatic report_test(input string name);
    if (errors == errors_before) begin
      $display("%s: ok", name);
      passes++;
    end else begin
      $display("%s: %0d errors", name, errors - errors_before);
      fails++;
    end
    errors_before = errors;
  endtask

  // Watchdog sized from the test lengths and worst VRAM delay
  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("Watchdog expired before the tests completed");
    $display("test failed");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    screen_mode = MODE_G4;
    reg_wr_req  = 1'b0;
    reg_num     = '0;
    reg_data    = '0;
    mode_now    = MODE_G4;
    last_op     = OP_STOP;
    lop_now     = LOG_IMP;
    transp_now  = 1'b0;
    clr_now     = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    expect_value("ce", 8'(ce), 8'h00);
    expect_value("vram_rd_req", 8'(vram_rd_req), 8'h00);
    expect_value("vram_wr_req", 8'(vram_wr_req), 8'h00);
    expect_value("reg_wr_ack", 8'(reg_wr_ack), 8'h00);
    expect_value("clr", clr, 8'h00);
    for (int a = 0; a < VRAM_BYTES; a++) shadow[a] = vram_i.mem[a];
    report_test("reset values");

    // Full byte in GRAPHIC 7, one nibble in GRAPHIC 4
    set_mode(MODE_G7);
    set_colour(8'ha7);
    set_mode(MODE_G4);
    set_colour(8'ha7);
    report_test("register writes and clr mask");

    for (int i = 0; i < 5; i++) begin
      write_word(REG_DX_LO, 33 + i);
      write_word(REG_DY_LO, 77);
      set_colour(8'(8'hf5 + i * 3));
      run_command(8'h50 | 8'(i));
      model_rect(1'b0, 33 + i, 77, 1, 1, 1'b0, 1'b0);
      check_memory("PSET");
    end
    report_test("pset logical ops g4");

    // Leftward fill, second pass with an unmasked byte
    set_mode(MODE_G5);
    set_rect(60, 10, 16, 3, 8'h04);
    for (int k = 0; k < 2; k++) begin
      set_colour((k == 0) ? 8'hb6 : 8'h6d);
      run_command(8'hc0);
      model_rect(1'b1, 60, 10, 16, 3, 1'b1, 1'b0);
      check_memory("HMMV");
    end
    report_test("hmmv fill g5");

    // Transparent zero leaves memory alone, then an upward fill
    set_mode(MODE_G7);
    set_rect(100, 40, 6, 4, 8'h08);
    for (int k = 0; k < 2; k++) begin
      set_colour((k == 0) ? 8'h00 : 8'h5b);
      run_command(8'h88);
      model_rect(1'b0, 100, 40, 6, 4, 1'b0, 1'b1);
      check_memory("LMMV");
    end
    report_test("lmmv transparent g7");

    set_mode(MODE_G6);
    write_word(REG_SX_LO, 37);
    write_word(REG_SY_LO, 300);
    run_command(8'h40);
    // CLR takes the POINT result the cycle after ce drops
    @(negedge clk);
    expect_value("clr", clr,
                 (shadow[byte_addr(MODE_G6, 37, 300)] >> pixel_shift(MODE_G6, 37)) & 8'h0f);
    // Large fill cut short by STOP
    set_rect(0, 0, 256, 64, 8'h00);
    write_reg(REG_CMR, 8'hc0);
    last_op = OP_HMMV;
    repeat (4) @(negedge clk);
    expect_value("ce", 8'(ce), 8'h01);
    run_command(8'h00);
    report_test("point g6 and stop");

    $display("summary: %0d tests ok, %0d tests with errors", passes, fails);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
src/vdp_mode_pkg.sv
src/vdp_cmd_pkg.sv
src/vdp_cmd_regs_if.sv
src/vdp_cmd_regs.sv
src/vdp_pixel_unit.sv
src/vdp_cmd_seq.sv
src/vdp_command.sv
dv/vram_model.sv
dv/tb_vdp_command.sv

/* run.sh */
#!/bin/sh
# Build the VDP command engine testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vdp_command -f sources.f

./obj_dir/Vtb_vdp_command | tee sim.log

# The run passes only if the pass message is in the log
grep -qx "test passed" sim.log
echo "simulation passed"
